// File: all.f
+incdir+test
source/panelPkg.sv
source/panelControl.sv
source/roomStatusStore.sv
source/spriteSweep.sv
source/homePanel.sv
test/homePanelTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module homePanelTb

out=$(./obj_dir/VhomePanelTb || true)
echo "$out"

echo "$out" | grep -q "TEST PASS"

// File: source/homePanel.sv
`timescale 1ns/1ps

module homePanel #(
	parameter int iconSize = 4, // icon side in pixels
	parameter int screenWidth = 160,
	parameter int screenHeight = 120
) (
	input logic clock,
	input logic reset,
	input logic [panelPkg::roomCount-1:0] roomSelect,
	input logic isLight,
	input logic isOn,
	input logic load,
	input logic clear,
	input logic lockedAll,
	output panelPkg::plotPixel pixel,
	output logic plot,
	output panelPkg::announceMessage message,
	output logic announce
);

	logic capture;
	panelPkg::roomIndex captureRoom;
	logic start, clearMode, sweepDone;
	panelPkg::roomStatus status;
	panelPkg::drawRequest request;

	// sequencing of load, draw, clear and announce
	panelControl u_panelControl (
		.clock(clock),
		.reset(reset),
		.roomSelect(roomSelect),
		.load(load),
		.clear(clear),
		.lockedAll(lockedAll),
		.sweepDone(sweepDone),
		.status(status),
		.capture(capture),
		.captureRoom(captureRoom),
		.start(start),
		.clearMode(clearMode),
		.announce(announce),
		.message(message)
	);

	roomStatusStore u_roomStatusStore (
		.clock(clock),
		.reset(reset),
		.capture(capture),
		.captureRoom(captureRoom),
		.isLight(isLight),
		.isOn(isOn),
		.status(status),
		.request(request)
	);

	spriteSweep #(
		.iconSize(iconSize),
		.screenWidth(screenWidth),
		.screenHeight(screenHeight)
	) u_spriteSweep (
		.clock(clock),
		.reset(reset),
		.start(start),
		.clearMode(clearMode),
		.request(request),
		.plot(plot),
		.pixel(pixel),
		.sweepDone(sweepDone)
	);

endmodule

// File: source/panelControl.sv
`timescale 1ns/1ps

module panelControl (
	input logic clock,
	input logic reset,
	input logic [panelPkg::roomCount-1:0] roomSelect, // one-hot-ish, lowest wins
	input logic load, // load button level
	input logic clear, // clear button level
	input logic lockedAll,
	input logic sweepDone, // last pixel of a sweep
	input panelPkg::roomStatus status, // status of the room just captured
	output logic capture, // write the store this cycle
	output panelPkg::roomIndex captureRoom,
	output logic start, // kick the sweep
	output logic clearMode, // full screen black sweep
	output logic announce, // message valid strobe
	output panelPkg::announceMessage message
);

	typedef enum logic [2:0] {
		idle,
		loadHeld, // waiting for the load button to come back up
		startDraw,
		drawing,
		startClear,
		clearing,
		announcing
	} controlState;

	controlState state, nextState;
	panelPkg::roomIndex selectedRoom;
	panelPkg::announceMessage statusMessage, messageReg;
	logic anyRoom;
	logic loadReleased; // load dropped while held

	// priority encoder, scan downward so the lowest switch ends up winning
	always_comb begin
		selectedRoom = '0;
		for (int i = panelPkg::roomCount - 1; i >= 0; i--) begin
			if (roomSelect[i]) selectedRoom = panelPkg::roomIndex'(i);
		end
	end

	assign anyRoom = |roomSelect;
	assign loadReleased = (state == loadHeld) && !load;

	// message for the stored function and level
	always_comb begin
		case ({status.isLight, status.isOn})
			2'b11: statusMessage = panelPkg::lightOn;
			2'b10: statusMessage = panelPkg::lightOff;
			2'b01: statusMessage = panelPkg::doorOpen;
			default: statusMessage = panelPkg::doorClosed;
		endcase
	end

	always_comb begin
		nextState = state;
		case (state)
			idle: if (load) nextState = loadHeld;
			loadHeld: begin
				if (!load) begin
					if (anyRoom) nextState = startDraw;
					else if (lockedAll) nextState = announcing; // skip drawing entirely
					else nextState = idle;
				end
			end
			startDraw: nextState = drawing;
			drawing: if (sweepDone) nextState = announcing;
			startClear: nextState = clearing;
			clearing: if (sweepDone) nextState = idle; // clear stays silent
			announcing: nextState = idle;
			default: nextState = idle;
		endcase
		if (clear) nextState = startClear; // clear wins from anywhere
	end

	always_ff @(posedge clock) begin
		if (reset) state <= idle;
		else state <= nextState;
	end

	// hold the message until the announce cycle
	always_ff @(posedge clock) begin
		if (reset) begin
			messageReg <= panelPkg::lightOff;
		end else if (loadReleased && !anyRoom) begin
			messageReg <= panelPkg::allLocked;
		end else if (state == drawing && sweepDone) begin
			messageReg <= statusMessage;
		end
	end

	assign capture = loadReleased && anyRoom && !clear; // store written on the release edge
	assign captureRoom = selectedRoom;
	assign start = (state == startDraw) || (state == startClear);
	assign clearMode = (state == startClear);
	assign announce = (state == announcing);
	assign message = messageReg;

endmodule

// File: source/panelPkg.sv
package panelPkg;

	// room number 0 to 4, matches the switch position
	typedef logic [2:0] roomIndex;

	// frame buffer is 160x120 so these cover the whole screen
	typedef logic [7:0] xCoord; // pixel column
	typedef logic [6:0] yCoord; // pixel row
	typedef logic [2:0] pixelColor; // {red, green, blue}

	// stored per room
	typedef struct packed {
		logic isLight; // 1 light, 0 door
		logic isOn; // on or open
	} roomStatus;

	// icon placement handed to the sweep
	typedef struct packed {
		xCoord x; // top left column
		yCoord y; // top left row
		pixelColor color;
	} drawRequest;

	// one plotted pixel toward the frame buffer
	typedef struct packed {
		xCoord x;
		yCoord y;
		pixelColor color;
	} plotPixel;

	// spoken message codes
	typedef enum logic [2:0] {
		lightOff,
		lightOn,
		doorClosed,
		doorOpen,
		allLocked
	} announceMessage;

	localparam int roomCount = 5;
	localparam int roomPitch = 30; // column spacing between room icons
	localparam int leftMargin = 10; // first room column
	localparam yCoord lightRow = 7'd40; // light icons sit on this row
	localparam yCoord doorRow = 7'd80; // door icons lower down
	localparam pixelColor colorOn = 3'b010; // green
	localparam pixelColor colorOff = 3'b100; // red
	localparam pixelColor colorBlank = 3'b000; // black, used by the clear sweep

endpackage

// File: source/roomStatusStore.sv
`timescale 1ns/1ps

module roomStatusStore (
	input logic clock,
	input logic reset,
	input logic capture,
	input panelPkg::roomIndex captureRoom,
	input logic isLight,
	input logic isOn,
	output panelPkg::roomStatus status, // entry of the last captured room
	output panelPkg::drawRequest request // where and how to draw it
);

	panelPkg::roomStatus rooms [panelPkg::roomCount];
	panelPkg::roomIndex lastRoom;
	logic validRoom;

	assign validRoom = captureRoom < panelPkg::roomIndex'(panelPkg::roomCount);

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < panelPkg::roomCount; i++) begin
				rooms[i] <= '0; // door, off
			end
			lastRoom <= '0;
		end else if (capture && validRoom) begin
			rooms[captureRoom] <= '{isLight: isLight, isOn: isOn};
			lastRoom <= captureRoom; // later draw and message follow this room
		end
	end

	assign status = rooms[lastRoom];

	// coordinate table, one column per room and one row per function
	always_comb begin
		request.x = panelPkg::xCoord'(panelPkg::leftMargin + int'(lastRoom) * panelPkg::roomPitch);
		request.y = status.isLight ? panelPkg::lightRow : panelPkg::doorRow;
		request.color = status.isOn ? panelPkg::colorOn : panelPkg::colorOff;
	end

endmodule

// File: source/spriteSweep.sv
`timescale 1ns/1ps

module spriteSweep #(
	parameter int iconSize = 4,
	parameter int screenWidth = 160,
	parameter int screenHeight = 120
) (
	input logic clock,
	input logic reset,
	input logic start, // begin a new box, abandons any running one
	input logic clearMode, // sweep the whole screen in black
	input panelPkg::drawRequest request,
	output logic plot, // pixel valid
	output panelPkg::plotPixel pixel,
	output logic sweepDone // with the last pixel
);

	// box extents kept as last index so they fit the coordinate widths
	localparam panelPkg::xCoord iconLastX = panelPkg::xCoord'(iconSize - 1);
	localparam panelPkg::yCoord iconLastY = panelPkg::yCoord'(iconSize - 1);
	localparam panelPkg::xCoord screenLastX = panelPkg::xCoord'(screenWidth - 1);
	localparam panelPkg::yCoord screenLastY = panelPkg::yCoord'(screenHeight - 1);

	panelPkg::xCoord originX, lastCol, colCount;
	panelPkg::yCoord originY, lastRow, rowCount;
	panelPkg::pixelColor color;
	logic active;
	logic lastPixel;

	assign lastPixel = (colCount == lastCol) && (rowCount == lastRow);

	always_ff @(posedge clock) begin
		if (reset) begin
			active <= 1'b0;
			colCount <= '0;
			rowCount <= '0;
		end else if (start) begin
			active <= 1'b1;
			colCount <= '0;
			rowCount <= '0;
		end else if (active) begin
			if (colCount == lastCol) begin // end of line, wrap to next row
				colCount <= '0;
				rowCount <= rowCount + 1'b1;
			end else begin
				colCount <= colCount + 1'b1; // x runs fastest
			end
			if (lastPixel) active <= 1'b0;
		end
	end

	// box origin, extent and color taken once per sweep
	always_ff @(posedge clock) begin
		if (start) begin
			if (clearMode) begin
				originX <= '0;
				originY <= '0;
				color <= panelPkg::colorBlank;
				lastCol <= screenLastX;
				lastRow <= screenLastY;
			end else begin
				originX <= request.x;
				originY <= request.y;
				color <= request.color;
				lastCol <= iconLastX;
				lastRow <= iconLastY;
			end
		end
	end

	assign plot = active && !start; // a restart drops the old box at once
	assign sweepDone = plot && lastPixel;
	assign pixel.x = originX + colCount;
	assign pixel.y = originY + rowCount;
	assign pixel.color = color;

endmodule

// File: test/panelCases.svh
`ifndef PANEL_CASES_SVH
`define PANEL_CASES_SVH

// values of the clear column
localparam logic [1:0] noClear = 2'd0;
localparam logic [1:0] clearOnly = 2'd1; // clear button pressed alone
localparam logic [1:0] clearMidDraw = 2'd2; // clear pressed while an icon is drawn

typedef struct packed {
	logic [panelPkg::roomCount-1:0] rooms; // room switches, bit 0 is room 0
	logic isLight; // 1 light, 0 door
	logic isOn;
	logic lockedAll;
	logic [1:0] clearKind;
	logic announces; // 0 means no announce expected
	panelPkg::announceMessage message; // only meaningful with announces
} caseRow;

localparam int tableRows = 12;

// columns are rooms, isLight, isOn, lockedAll, clear, announces, message
caseRow caseTable [tableRows] = '{
	'{5'b00001, 1'b1, 1'b1, 1'b0, noClear, 1'b1, panelPkg::lightOn}, // room 0 light on
	'{5'b00010, 1'b1, 1'b0, 1'b0, noClear, 1'b1, panelPkg::lightOff},
	'{5'b00100, 1'b0, 1'b1, 1'b0, noClear, 1'b1, panelPkg::doorOpen},
	'{5'b01000, 1'b0, 1'b0, 1'b0, noClear, 1'b1, panelPkg::doorClosed},
	'{5'b10110, 1'b1, 1'b1, 1'b0, noClear, 1'b1, panelPkg::lightOn}, // room 1 wins
	'{5'b00000, 1'b0, 1'b0, 1'b1, noClear, 1'b1, panelPkg::allLocked}, // no drawing
	'{5'b00000, 1'b0, 1'b0, 1'b0, noClear, 1'b0, panelPkg::lightOff}, // silent release
	'{5'b00001, 1'b0, 1'b1, 1'b0, noClear, 1'b1, panelPkg::doorOpen}, // room 0 moves down
	'{5'b00100, 1'b0, 1'b1, 1'b0, noClear, 1'b1, panelPkg::doorOpen}, // room 2 redrawn
	'{5'b00000, 1'b0, 1'b0, 1'b0, clearOnly, 1'b0, panelPkg::lightOff},
	'{5'b10000, 1'b1, 1'b1, 1'b0, clearMidDraw, 1'b0, panelPkg::lightOff},
	'{5'b10000, 1'b0, 1'b0, 1'b0, noClear, 1'b1, panelPkg::doorClosed}
};

// lowest switch that is set, -1 with none
function automatic int lowestRoom(input logic [panelPkg::roomCount-1:0] rooms);
	int found;
	found = -1;
	for (int i = 0; i < panelPkg::roomCount; i++) begin
		if (((rooms >> i) & 5'd1) != 5'd0 && found < 0) found = i;
	end
	return found;
endfunction

function automatic int iconX(input int room);
	return panelPkg::leftMargin + room * panelPkg::roomPitch; // one column per room
endfunction

function automatic int iconY(input logic light);
	return light ? int'(panelPkg::lightRow) : int'(panelPkg::doorRow);
endfunction

function automatic panelPkg::pixelColor iconColor(input logic on);
	return on ? panelPkg::colorOn : panelPkg::colorOff;
endfunction

function automatic panelPkg::announceMessage messageFor(input logic light, input logic on);
	if (light) return on ? panelPkg::lightOn : panelPkg::lightOff;
	return on ? panelPkg::doorOpen : panelPkg::doorClosed;
endfunction

`endif

// File: test/homePanelTb.sv
`timescale 1ns/1ps

module homePanelTb;

	localparam int iconSize = 4;
	localparam int screenWidth = 160;
	localparam int screenHeight = 120;
	localparam int randomRows = 4; // extra rows with random function and level
	localparam int marginCycles = 100; // reset and settling slack

	logic clock = 1'b0;
	logic reset;
	logic [panelPkg::roomCount-1:0] roomSelect;
	logic isLight;
	logic isOn;
	logic load;
	logic clear;
	logic lockedAll;
	panelPkg::plotPixel pixel;
	logic plot;
	panelPkg::announceMessage message;
	logic announce;

	`include "panelCases.svh"

	// expected sweep box, written by the stimulus
	int boxX, boxY, boxW, boxH;
	int boxBase; // pixel total when the box was set
	panelPkg::pixelColor boxColor;
	int announcesAllowed;
	panelPkg::announceMessage expMessage;
	// written by the monitors
	int pixTotal = 0;
	int announceTotal = 0;
	int cycleCount = 0;
	int timeoutLimit;

	homePanel #(
		.iconSize(iconSize),
		.screenWidth(screenWidth),
		.screenHeight(screenHeight)
	) u_homePanel (
		.clock(clock),
		.reset(reset),
		.roomSelect(roomSelect),
		.isLight(isLight),
		.isOn(isOn),
		.load(load),
		.clear(clear),
		.lockedAll(lockedAll),
		.pixel(pixel),
		.plot(plot),
		.message(message),
		.announce(announce)
	);

	always #5 clock = ~clock;

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			abortRun($sformatf("ERR %s got 0x%0h expected 0x%0h", name, actual, expected));
		end
	endtask

	task automatic expectBox(input int x, input int y, input int w, input int h,
			input panelPkg::pixelColor color);
		boxX = x;
		boxY = y;
		boxW = w;
		boxH = h;
		boxColor = color;
		boxBase = pixTotal; // count restarts for the new box
	endtask

	task automatic waitSweep();
		while (pixTotal - boxBase < boxW * boxH) begin
			@(posedge clock);
			#1;
		end
	endtask

	task automatic runRow(input caseRow row);
		int room;
		int edges;
		room = lowestRoom(row.rooms);
		roomSelect = row.rooms;
		isLight = row.isLight;
		isOn = row.isOn;
		lockedAll = row.lockedAll;
		if (row.clearKind == clearOnly) begin
			expectBox(0, 0, screenWidth, screenHeight, panelPkg::colorBlank);
			clear = 1'b1; // one cycle press
			@(posedge clock);
			#1;
			clear = 1'b0;
			waitSweep();
		end else begin
			if (room >= 0) begin
				expectBox(iconX(room), iconY(row.isLight), iconSize, iconSize,
					iconColor(row.isOn));
			end else begin
				expectBox(0, 0, 0, 0, panelPkg::colorBlank); // nothing may be plotted
			end
			expMessage = row.message;
			if (row.announces) announcesAllowed++;
			load = 1'b1;
			repeat (2) begin
				@(posedge clock);
				#1;
			end
			load = 1'b0; // release edge captures the room
			if (row.clearKind == clearMidDraw) begin
				while (pixTotal - boxBase < 3) begin
					@(posedge clock);
					#1;
				end
				clear = 1'b1;
				@(posedge clock);
				#1;
				clear = 1'b0;
				expectBox(0, 0, screenWidth, screenHeight, panelPkg::colorBlank); // icon abandoned
				waitSweep();
			end else if (row.announces) begin
				edges = 0;
				do begin
					@(posedge clock);
					edges++;
					@(negedge clock);
				end while (announce !== 1'b1);
				checkValue("announce delay", edges, room >= 0 ? iconSize * iconSize + 2 : 1);
				@(posedge clock);
				#1;
				checkValue("pixel count", pixTotal - boxBase, boxW * boxH);
			end else begin
				repeat (6) begin
					@(posedge clock);
					#1;
				end
			end
		end
		repeat (2) begin
			@(posedge clock);
			#1;
		end
		checkValue("announce count", announceTotal, announcesAllowed);
	endtask

	// pixel and announce monitor, outputs settled by the falling edge
	always @(negedge clock) begin
		if (plot === 1'b1) begin
			if (pixTotal - boxBase >= boxW * boxH) begin
				abortRun("plot pulsed with no pixel left in the expected sweep");
			end else begin
				checkValue("pixel.x", 32'(pixel.x), boxX + (pixTotal - boxBase) % boxW);
				checkValue("pixel.y", 32'(pixel.y), boxY + (pixTotal - boxBase) / boxW);
				checkValue("pixel.color", 32'(pixel.color), 32'(boxColor));
				pixTotal++;
			end
		end
		if (announce === 1'b1) begin
			if (announceTotal >= announcesAllowed) begin
				abortRun("announce pulsed when no message was due");
			end else begin
				checkValue("message", 32'(message), 32'(expMessage));
				announceTotal++;
			end
		end
	end

	always @(posedge clock) begin
		cycleCount++;
		if (cycleCount > timeoutLimit) abortRun("run timed out waiting for the DUT");
	end

	initial begin
		caseRow row;
		int clearRows;
		reset = 1'b1;
		roomSelect = '0;
		isLight = 1'b0;
		isOn = 1'b0;
		load = 1'b0;
		clear = 1'b0;
		lockedAll = 1'b0;
		announcesAllowed = 0;
		expMessage = panelPkg::lightOff;
		expectBox(0, 0, 0, 0, panelPkg::colorBlank);
		void'($urandom(94438));
		clearRows = 0;
		for (int i = 0; i < tableRows; i++) begin
			if (caseTable[i].clearKind != noClear) clearRows++;
		end
		timeoutLimit = (tableRows + randomRows) * (iconSize * iconSize + 10)
			+ clearRows * screenWidth * screenHeight + marginCycles;
		repeat (5) @(posedge clock);
		#1;
		reset = 1'b0;
		// quiet outputs before any load
		repeat (3) begin
			@(negedge clock);
			checkValue("plot", 32'(plot), 0);
			checkValue("announce", 32'(announce), 0);
		end
		@(posedge clock);
		#1;
		for (int i = 0; i < tableRows; i++) runRow(caseTable[i]);
		for (int i = 0; i < randomRows; i++) begin
			row.rooms = 5'(1 << (i % panelPkg::roomCount)); // walk the rooms
			row.isLight = 1'($urandom % 2);
			row.isOn = 1'($urandom % 2);
			row.lockedAll = 1'b0;
			row.clearKind = noClear;
			row.announces = 1'b1;
			row.message = messageFor(row.isLight, row.isOn);
			runRow(row);
		end
		$display("TEST PASS");
		$finish;
	end

endmodule
